/* vlog.f */
rtl/cache_pkg.sv
rtl/l1_cache.sv
rtl/bus_arbiter.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
dv/bus_arbiter_props.sv
dv/cache_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_subsystem_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/cache_subsystem_tb.sv */
`timescale 1ns/100ps

module cache_subsystem_tb;

    localparam int TIMEOUT_CYCLES = 4000;  // ~90 accesses at up to ~28 cycles under contention
    localparam logic [31:0] SEED = 32'h0ef8_f319;
    localparam cache_pkg::word_t CONFLICT_BASE = 32'h0000_0428;  // set 5, tag 8
    localparam int PRELOAD_WORDS = 16;

    logic                CLK;
    logic                nRST;
    logic                flush;
    cache_pkg::bus_req_t i_req, d_req;
    cache_pkg::bus_rsp_t i_rsp, d_rsp;
    logic                i_flush_done, d_flush_done;

    cache_pkg::word_t cpu_model [cache_pkg::MEM_DEPTH];  // what a cached read returns
    cache_pkg::word_t mem_model [cache_pkg::MEM_DEPTH];  // what memory itself holds
    cache_pkg::word_t written_q [$];
    int n_errors, n_reads, cycle_cnt;

    cache_subsystem dut0 (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .i_req        (i_req),
        .d_req        (d_req),
        .i_rsp        (i_rsp),
        .d_rsp        (d_rsp),
        .i_flush_done (i_flush_done),
        .d_flush_done (d_flush_done)
    );

    always #20 CLK = ~CLK;

    // uncached reads see memory, even where a cache still holds a dirty copy
    function automatic cache_pkg::word_t expected_read(input cache_pkg::word_t addr);
        if (addr >= cache_pkg::NONCACHE_START_ADDR) begin
            return mem_model[addr[11:2]];
        end
        return cpu_model[addr[11:2]];
    endfunction

    task automatic record_write(input cache_pkg::word_t addr, input cache_pkg::word_t data);
        if (addr >= cache_pkg::NONCACHE_START_ADDR) begin
            mem_model[addr[11:2]] = data;  // only done where no cache holds the word
        end
        cpu_model[addr[11:2]] = data;
    endtask

    task automatic check_value(input string name, input cache_pkg::word_t expected,
                               input cache_pkg::word_t actual);
        if (expected !== actual) begin
            n_errors++;
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic to_drive_point;
        @(posedge CLK);
        #2;
    endtask

    task automatic d_access(input logic wr, input cache_pkg::word_t addr,
                            input cache_pkg::word_t wdata);
        d_req.ren      = ~wr;
        d_req.wen      = wr;
        d_req.addr.raw = addr;
        d_req.wdata    = wdata;
        @(negedge CLK);
        while (d_rsp.busy) @(negedge CLK);
        if (wr) record_write(addr, wdata);
        to_drive_point();
        d_req = '0;
    endtask

    task automatic i_read(input cache_pkg::word_t addr);
        i_req.ren      = 1'b1;
        i_req.addr.raw = addr;
        @(negedge CLK);
        while (i_rsp.busy) @(negedge CLK);
        to_drive_point();
        i_req = '0;
    endtask

    task automatic run_flush;
        logic i_seen, d_seen;
        i_seen = 1'b0;
        d_seen = 1'b0;
        flush  = 1'b1;
        to_drive_point();
        flush = 1'b0;
        while (!(i_seen && d_seen)) begin
            @(negedge CLK);
            if (i_flush_done) i_seen = 1'b1;
            if (d_flush_done) d_seen = 1'b1;
        end
        to_drive_point();
    endtask

    // every completed read goes through the reference model
    always @(negedge CLK) begin
        if (nRST && d_req.ren && !d_rsp.busy) begin
            n_reads++;
            check_value("d_rsp.rdata", expected_read(d_req.addr.raw), d_rsp.rdata);
        end
        if (nRST && i_req.ren && !i_rsp.busy) begin
            n_reads++;
            check_value("i_rsp.rdata", expected_read(i_req.addr.raw), i_rsp.rdata);
        end
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("reads checked %0d, errors %0d", n_reads, n_errors);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        cache_pkg::word_t addr;
        CLK       = 1'b0;
        nRST      = 1'b0;
        flush     = 1'b0;
        i_req     = '0;
        d_req     = '0;
        n_errors  = 0;
        n_reads   = 0;
        cycle_cnt = 0;
        void'($urandom(SEED));
        foreach (cpu_model[k]) begin
            cpu_model[k] = '0;
            mem_model[k] = '0;
        end
        repeat (10) @(posedge CLK);
        #2 nRST = 1'b1;

        @(negedge CLK);
        check_value("i_rsp.busy", 32'(1), 32'(i_rsp.busy));
        check_value("d_rsp.busy", 32'(1), 32'(d_rsp.busy));
        check_value("i_flush_done", 32'(0), 32'(i_flush_done));
        check_value("d_flush_done", 32'(0), 32'(d_flush_done));
        to_drive_point();

        // random writes then read back
        repeat (8) begin
            addr = 32'($urandom_range(0, 63)) << 2;
            d_access(1'b1, addr, $urandom);
            written_q.push_back(addr);
        end
        foreach (written_q[k]) d_access(1'b0, written_q[k], '0);

        // memory copy of the third conflict address, soon stale
        d_access(1'b1, CONFLICT_BASE + 32'h100 + cache_pkg::NONCACHE_START_ADDR, $urandom);
        for (int k = 0; k < 3; k++) begin
            addr = CONFLICT_BASE + 32'(k) * 32'h80;
            d_access(1'b1, addr, $urandom);  // third one evicts the dirty first
            written_q.push_back(addr);
        end
        d_access(1'b0, CONFLICT_BASE, '0);

        // alias of a dirty word still shows the old memory value
        d_access(1'b0, CONFLICT_BASE + 32'h100 + cache_pkg::NONCACHE_START_ADDR, '0);

        run_flush();
        foreach (cpu_model[k]) mem_model[k] = cpu_model[k];
        foreach (written_q[k]) begin
            d_access(1'b0, written_q[k] | cache_pkg::NONCACHE_START_ADDR, '0);
        end

        // instruction words placed straight into memory
        for (int k = 0; k < PRELOAD_WORDS; k++) begin
            d_access(1'b1, 32'h8000_0800 + 32'(k) * 4, $urandom);
        end
        fork
            repeat (20) i_read(32'h800 + (32'($urandom_range(0, PRELOAD_WORDS - 1)) << 2));
            repeat (20) begin
                d_access(1'($urandom_range(0, 1)), 32'($urandom_range(0, 63)) << 2, $urandom);
            end
        join

        $display("reads checked %0d, errors %0d", n_reads, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* dv/bus_arbiter_props.sv */
`timescale 1ns/100ps

module bus_arbiter_props (
    input logic                CLK,
    input logic                nRST,
    input cache_pkg::bus_req_t req0,
    input cache_pkg::bus_req_t req1,
    input cache_pkg::bus_rsp_t rsp0,
    input cache_pkg::bus_rsp_t rsp1,
    input cache_pkg::bus_req_t mem_req,
    input logic                owner,
    input logic                active
);

    logic owner_strobe;

    assign owner_strobe = owner ? (req1.ren | req1.wen) : (req0.ren | req0.wen);

    // a completion goes to one requester only, and memory saw that requester's access
    one_completion: assert property (@(posedge CLK) disable iff (!nRST)
        (!rsp0.busy |-> (rsp1.busy && (req0.ren | req0.wen) && mem_req == req0)) and
        (!rsp1.busy |-> (rsp0.busy && (req1.ren | req1.wen) && mem_req == req1)))
        else $error("completion seen by a requester whose access was not on the memory bus");

    one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("read and write strobes high together on the memory bus");

    owner_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (active && owner_strobe) |=> (owner == $past(owner)))
        else $error("bus owner changed while its strobe was high");

endmodule

bind bus_arbiter bus_arbiter_props props0 (
    .CLK     (CLK),
    .nRST    (nRST),
    .req0    (req0),
    .req1    (req1),
    .rsp0    (rsp0),
    .rsp1    (rsp1),
    .mem_req (mem_req),
    .owner   (owner),
    .active  (active)
);

/* rtl/cache_subsystem.sv */
`timescale 1ns/100ps

module cache_subsystem (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    input  cache_pkg::bus_req_t i_req,
    input  cache_pkg::bus_req_t d_req,
    output cache_pkg::bus_rsp_t i_rsp,
    output cache_pkg::bus_rsp_t d_rsp,
    output logic                i_flush_done,
    output logic                d_flush_done
);

    cache_pkg::bus_req_t i_mem_req, d_mem_req, mem_req;
    cache_pkg::bus_rsp_t i_mem_rsp, d_mem_rsp, mem_rsp;

    // instruction side
    l1_cache icache0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (i_flush_done),
        .proc_req   (i_req),
        .proc_rsp   (i_rsp),
        .mem_req    (i_mem_req),
        .mem_rsp    (i_mem_rsp)
    );

    l1_cache dcache0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (d_flush_done),
        .proc_req   (d_req),
        .proc_rsp   (d_rsp),
        .mem_req    (d_mem_req),
        .mem_rsp    (d_mem_rsp)
    );

    bus_arbiter arb0 (
        .CLK     (CLK),
        .nRST    (nRST),
        .req0    (i_mem_req),
        .req1    (d_mem_req),
        .rsp0    (i_mem_rsp),
        .rsp1    (d_mem_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    main_memory mem0 (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (mem_req),
        .rsp  (mem_rsp)
    );

endmodule

/* rtl/main_memory.sv */
`timescale 1ns/100ps

module main_memory (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::bus_req_t req,
    output cache_pkg::bus_rsp_t rsp
);

    cache_pkg::word_t mem [cache_pkg::MEM_DEPTH];

    logic [$clog2(cache_pkg::MEM_WAIT_CYCLES+1)-1:0] wait_cnt;
    logic [$clog2(cache_pkg::MEM_DEPTH)-1:0]         idx;
    logic strobe, done;

    // word index, upper bits ignored so uncached addresses alias
    assign idx    = req.addr.raw[11:2];
    assign strobe = req.ren | req.wen;
    assign done   = strobe && (wait_cnt == $bits(wait_cnt)'(cache_pkg::MEM_WAIT_CYCLES));

    assign rsp.busy  = ~done;
    assign rsp.rdata = mem[idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
            mem      <= '{default: '0};
        end else begin
            if (done || !strobe) begin
                wait_cnt <= '0;   // restart for the next word
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (done && req.wen) begin
                mem[idx] <= req.wdata;
            end
        end
    end

endmodule

/* rtl/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::bus_req_t req0,
    input  cache_pkg::bus_req_t req1,
    output cache_pkg::bus_rsp_t rsp0,
    output cache_pkg::bus_rsp_t rsp1,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp
);

    logic strobe0, strobe1;
    logic owner, active, last_grant;
    logic keep, grant, grant_valid;

    assign strobe0 = req0.ren | req0.wen;
    assign strobe1 = req1.ren | req1.wen;

    // current owner keeps the bus for as long as it holds a strobe
    assign keep = active && (owner ? strobe1 : strobe0);

    always_comb begin
        grant       = owner;
        grant_valid = 1'b1;
        if (keep) begin
            grant = owner;
        end else if (strobe0 && strobe1) begin
            grant = ~last_grant;   // round robin
        end else if (strobe0) begin
            grant = 1'b0;
        end else if (strobe1) begin
            grant = 1'b1;
        end else begin
            grant_valid = 1'b0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner      <= 1'b0;
            active     <= 1'b0;
            last_grant <= 1'b1;   // first contest goes to req0
        end else begin
            active <= grant_valid;
            if (grant_valid) owner <= grant;
            if (grant_valid && !keep) last_grant <= grant;
        end
    end

    assign mem_req = !grant_valid ? '0 : (grant ? req1 : req0);

    // loser sees busy high
    assign rsp0.rdata = mem_rsp.rdata;
    assign rsp0.busy  = mem_rsp.busy | ~grant_valid | grant;
    assign rsp1.rdata = mem_rsp.rdata;
    assign rsp1.busy  = mem_rsp.busy | ~grant_valid | ~grant;

endmodule

/* rtl/l1_cache.sv */
`timescale 1ns/100ps

module l1_cache (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    output logic                flush_done,
    input  cache_pkg::bus_req_t proc_req,
    output cache_pkg::bus_rsp_t proc_rsp,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp
);

    typedef enum logic [2:0] {
        IDLE, FETCH, WB, FLUSH_SET, FLUSH_FRAME, PASS
    } state_t;

    state_t state, next_state;

    // frame array, split so only valid/dirty carry a reset
    logic [cache_pkg::ASSOC-1:0]      valid     [cache_pkg::N_SETS];
    logic [cache_pkg::ASSOC-1:0]      dirty     [cache_pkg::N_SETS];
    logic [cache_pkg::N_TAG_BITS-1:0] tag_arr   [cache_pkg::N_SETS][cache_pkg::ASSOC];
    cache_pkg::word_t                 data_arr  [cache_pkg::N_SETS][cache_pkg::ASSOC]
                                                [cache_pkg::BLOCK_SIZE];
    logic [cache_pkg::N_SETS-1:0]     last_used;

    logic [cache_pkg::N_BLOCK_BITS-1:0] word_cnt;
    logic                               frame_cnt;
    logic [cache_pkg::N_SET_BITS-1:0]   set_cnt;

    cache_pkg::addr_u a;
    logic strobe, pass_through, hit, hit_way, victim;
    logic mem_ack, last_word, cur_dirty, last_slot;
    logic hit_acc, hit_wr, fill_we, fill_last, flush_wb_last;

    assign a            = proc_req.addr;
    assign strobe       = proc_req.ren | proc_req.wen;
    assign pass_through = a.raw >= cache_pkg::NONCACHE_START_ADDR;
    assign victim       = ~last_used[a.f.set_idx];   // frame not used last

    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < cache_pkg::ASSOC; w++) begin
            if (valid[a.f.set_idx][w] && tag_arr[a.f.set_idx][w] == a.f.tag) begin
                hit     = 1'b1;
                hit_way = w[0];
            end
        end
        hit = hit & ~pass_through;
    end

    assign mem_ack   = ~mem_rsp.busy & (mem_req.ren | mem_req.wen);
    assign last_word = &word_cnt;
    assign cur_dirty = dirty[set_cnt][frame_cnt];
    assign last_slot = frame_cnt & (&set_cnt);   // last frame of last set

    assign hit_acc       = (state == IDLE) && strobe && hit;
    assign hit_wr        = hit_acc && proc_req.wen;
    assign fill_we       = (state == FETCH) && mem_ack;
    assign fill_last     = fill_we && last_word;
    assign flush_wb_last = (state == FLUSH_FRAME) && mem_ack && last_word;

    // bus outputs
    always_comb begin
        proc_rsp   = '{busy: 1'b1, rdata: '0};
        mem_req    = '0;
        flush_done = 1'b0;
        case (state)
            IDLE: begin
                if (hit_acc) begin
                    proc_rsp.busy  = 1'b0;
                    proc_rsp.rdata = data_arr[a.f.set_idx][hit_way][a.f.blk];
                end
            end
            FETCH: begin
                mem_req.ren    = 1'b1;
                mem_req.addr.f = '{tag: a.f.tag, set_idx: a.f.set_idx,
                                   blk: word_cnt, byte_off: 2'b00};
            end
            WB: begin
                mem_req.wen    = 1'b1;
                mem_req.addr.f = '{tag: tag_arr[a.f.set_idx][victim], set_idx: a.f.set_idx,
                                   blk: word_cnt, byte_off: 2'b00};
                mem_req.wdata  = data_arr[a.f.set_idx][victim][word_cnt];
            end
            FLUSH_SET: begin
                flush_done = ~cur_dirty & last_slot;
            end
            FLUSH_FRAME: begin
                // address rebuilt from stored tag and walk position
                mem_req.wen    = 1'b1;
                mem_req.addr.f = '{tag: tag_arr[set_cnt][frame_cnt], set_idx: set_cnt,
                                   blk: word_cnt, byte_off: 2'b00};
                mem_req.wdata  = data_arr[set_cnt][frame_cnt][word_cnt];
            end
            PASS: begin
                mem_req  = proc_req;
                proc_rsp = mem_rsp;
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (strobe && pass_through) begin
                    next_state = PASS;
                end else if (strobe && !hit) begin
                    next_state = dirty[a.f.set_idx][victim] ? WB : FETCH;
                end else if (!strobe && flush) begin
                    next_state = FLUSH_SET;
                end
            end
            FETCH:       if (mem_ack && last_word) next_state = IDLE;
            WB:          if (mem_ack && last_word) next_state = FETCH;
            FLUSH_SET: begin
                if (cur_dirty) begin
                    next_state = FLUSH_FRAME;
                end else if (last_slot) begin
                    next_state = IDLE;
                end
            end
            FLUSH_FRAME: if (flush_wb_last) next_state = FLUSH_SET;
            PASS:        if (!mem_rsp.busy) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            word_cnt  <= '0;
            frame_cnt <= 1'b0;
            set_cnt   <= '0;
            valid     <= '{default: '0};
            dirty     <= '{default: '0};
            last_used <= '0;
        end else begin
            state <= next_state;
            if (mem_ack && state != PASS) begin
                word_cnt <= word_cnt + 1'b1;   // wraps after the last word
            end
            if (hit_acc) begin
                last_used[a.f.set_idx] <= hit_way;
            end
            if (hit_wr) begin
                dirty[a.f.set_idx][hit_way] <= 1'b1;
            end
            if (fill_last) begin
                valid[a.f.set_idx][victim] <= 1'b1;
                dirty[a.f.set_idx][victim] <= 1'b0;
            end
            if (flush_wb_last) begin
                dirty[set_cnt][frame_cnt] <= 1'b0;
            end
            // flush walk position
            if (state == IDLE && next_state == FLUSH_SET) begin
                set_cnt   <= '0;
                frame_cnt <= 1'b0;
            end else if (state == FLUSH_SET && !cur_dirty) begin
                frame_cnt <= ~frame_cnt;
                if (frame_cnt) set_cnt <= set_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hit_wr) begin
            data_arr[a.f.set_idx][hit_way][a.f.blk] <= proc_req.wdata;
        end
        if (fill_we) begin
            data_arr[a.f.set_idx][victim][word_cnt] <= mem_rsp.rdata;
        end
        if (fill_last) begin
            tag_arr[a.f.set_idx][victim] <= a.f.tag;
        end
    end

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

    // bus and cache geometry
    localparam int WORD_SIZE    = 32;
    localparam int BLOCK_SIZE   = 2;   // words per block
    localparam int ASSOC        = 2;   // frames per set
    localparam int N_SETS       = 16;

    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int N_TAG_BITS   = WORD_SIZE - N_SET_BITS - N_BLOCK_BITS - 2;

    // everything at or above this goes straight to memory
    localparam logic [WORD_SIZE-1:0] NONCACHE_START_ADDR = 32'h8000_0000;

    // backing memory
    localparam int MEM_DEPTH       = 1024;
    localparam int MEM_WAIT_CYCLES = 2;

    typedef logic [WORD_SIZE-1:0] word_t;

    // lookup view of a byte address
    typedef struct packed {
        logic [N_TAG_BITS-1:0]   tag;
        logic [N_SET_BITS-1:0]   set_idx;
        logic [N_BLOCK_BITS-1:0] blk;      // word within block
        logic [1:0]              byte_off;
    } cache_addr_t;

    // raw word for memory and range check, fields for the tag lookup
    typedef union packed {
        word_t       raw;
        cache_addr_t f;
    } addr_u;

    // requester side of any bus, processor or memory
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_u addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  busy;   // high until the access completes
        word_t rdata;
    } bus_rsp_t;

endpackage
